// ==== logic/pr_stream_pkg.sv ====
/*
  Shared constants and types for the partial-reconfiguration stream shell.
  Every lane carries the one beat type axis_beat_t.
  CRED_BITS must be wide enough to hold both CREDITS and RG_CREDITS.
  CREDITS is also the sender's credit count after reset. It is the depth
  of each receive buffer.
*/
package pr_stream_pkg;

  localparam int N_REGIONS  = 4;                // Number of reconfigurable regions.
  localparam int DATA_BITS  = 64;               // Width of the beat payload.
  localparam int KEEP_BITS  = DATA_BITS / 8;    // One keep bit per payload byte.
  localparam int PID_BITS   = 6;                // Width of the process id.

  localparam int CREDITS    = 4;                // Receive buffer depth and sender credits.
  localparam int RG_CREDITS = 2;                // Credits granted by a freshly loaded region.
  localparam int CRED_BITS  = 3;                // Holds the larger of the two credit counts.
  localparam int PTR_BITS   = $clog2(CREDITS);  // Index width into the receive buffer.

  // One stream beat, the same shape on the static and the region side.
  typedef struct packed {
    logic [DATA_BITS-1:0] data;  // Payload.
    logic [KEEP_BITS-1:0] keep;  // Byte enables.
    logic [PID_BITS-1:0]  id;    // Process id of the owning stream.
    logic                 last;  // Marks the final beat of a packet.
  } axis_beat_t;

  // Per-lane reconfiguration state.
  typedef enum logic [1:0] {
    ACTIVE    = 2'd0,  // Region coupled, beats flow.
    DRAINING  = 2'd1,  // Decouple wanted, current packet still finishing.
    DECOUPLED = 2'd2   // Region cut off at a packet boundary.
  } lane_state_t;

endpackage

// ==== logic/credit_fifo.sv ====
/*
  Receive buffer for one lane, CREDITS entries deep.
  The sender must honor credits, so a write is never refused. A write into a
  full buffer overwrites data and is caught only by the bound assertions.
  A beat written in cycle t shows at rd_valid in t+1. A credit pulse
  follows each pop by one cycle.
*/
`timescale 1ns/1ps

module credit_fifo
  import pr_stream_pkg::*;
(
  input  logic       aclk,
  input  logic       arst_n,
  input  logic       wr_valid,
  input  axis_beat_t wr_beat,
  output logic       credit,
  output logic       rd_valid,
  output axis_beat_t rd_beat,
  input  logic       rd_pop
);

  axis_beat_t           mem [CREDITS];  // Beat storage.
  logic [PTR_BITS-1:0]  wr_ptr;         // Next slot to write.
  logic [PTR_BITS-1:0]  rd_ptr;         // Oldest stored beat.
  logic [CRED_BITS-1:0] fill;           // Number of stored beats.
  logic                 do_pop;         // Pop that really removes a beat.

  // Wraps a pointer at the buffer depth, which need not be a power of two.
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(CREDITS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rd_valid = (fill != '0);    // Anything stored is offered at once.
  assign rd_beat  = mem[rd_ptr];     // Head of the buffer, read without delay.
  assign do_pop   = rd_pop & rd_valid;  // A pop on an empty buffer is ignored.

  always_ff @(posedge aclk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_beat;  // Space is guaranteed by the sender's credits.
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      credit <= 1'b0;  // No credit returns until the first pop.
    end else begin
      credit <= do_pop;  // Each freed slot is handed back to the sender.
      if (wr_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      unique case ({wr_valid, do_pop})
        2'b10:   fill <= fill + 1'b1;  // Write only.
        2'b01:   fill <= fill - 1'b1;  // Pop only.
        default: fill <= fill;         // Both or neither leave the level as it is.
      endcase
    end
  end

endmodule

// ==== logic/region_decoupler.sv ====
/*
  Gate between one receive buffer and its reconfigurable region.
  A beat is popped only while the region credit counter is nonzero and the
  lane is not decoupled. The popped beat is registered and shows on
  out_valid one cycle later. While decoupled, credit pulses from the region
  are ignored. A reload pulse restores the counter to RG_CREDITS.
*/
`timescale 1ns/1ps

module region_decoupler
  import pr_stream_pkg::*;
(
  input  logic       aclk,
  input  logic       arst_n,
  input  logic       buf_valid,
  input  axis_beat_t buf_beat,
  output logic       buf_pop,
  output logic       out_valid,
  output axis_beat_t out_beat,
  input  logic       out_credit,
  input  logic       decouple,
  input  logic       reload,
  output logic       fire_last
);

  logic [CRED_BITS-1:0] rg_cnt;       // Credits the region still grants.
  logic                 take_credit;  // Credit pulse that is honored.

  // A beat leaves the buffer only with a region credit in hand and the lane coupled.
  assign buf_pop = buf_valid & (rg_cnt != '0) & ~decouple;

  // A region under reconfiguration may toggle its credit line at random.
  assign take_credit = out_credit & ~decouple;

  // The last beat of a packet, as seen on the region side.
  assign fire_last = out_valid & out_beat.last;

  always_ff @(posedge aclk) begin
    if (buf_pop) begin
      out_beat <= buf_beat;  // Output register, payload only.
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      rg_cnt    <= CRED_BITS'(RG_CREDITS);  // The region starts coupled and fresh.
    end else begin
      out_valid <= buf_pop;  // The popped beat is presented for one cycle.
      if (reload) begin
        rg_cnt <= CRED_BITS'(RG_CREDITS);  // New region, new grant.
      end else begin
        unique case ({buf_pop, take_credit})
          2'b10:   rg_cnt <= rg_cnt - 1'b1;  // Beat sent, one credit spent.
          2'b01:   rg_cnt <= rg_cnt + 1'b1;  // Region freed a slot.
          default: rg_cnt <= rg_cnt;         // Send and return cancel out.
        endcase
      end
    end
  end

endmodule

// ==== logic/reconfig_ctrl.sv ====
/*
  Reconfiguration controller shared by all lanes.
  Each lane tracks whether a packet is open on the region side. A decouple
  request is only honored between packets. A lane in mid-packet drains
  first. decouple also goes high in the cycle the lane commits to
  DECOUPLED, so that no new packet can start behind the last one.
  When the request falls, the lane re-couples and reload pulses once.
*/
`timescale 1ns/1ps

module reconfig_ctrl
  import pr_stream_pkg::*;
(
  input  logic                 aclk,
  input  logic                 arst_n,
  input  logic [N_REGIONS-1:0] decouple_req,
  input  logic [N_REGIONS-1:0] fire,
  input  logic [N_REGIONS-1:0] fire_last,
  output logic [N_REGIONS-1:0] decouple,
  output logic [N_REGIONS-1:0] reload,
  output logic [N_REGIONS-1:0] decoupled
);

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_lane
    lane_state_t lane_st;    // Current lane state.
    logic        in_pkt;     // A packet is open on the region side.
    logic        in_pkt_nx;  // Open flag including this cycle's beat.
    logic        boundary;   // The region is between packets after this cycle.

    // The current beat counts, so a single-beat packet never looks open.
    assign in_pkt_nx = fire[i] ? ~fire_last[i] : in_pkt;
    assign boundary  = ~in_pkt_nx;

    // Blocks the next pop as soon as the lane is sure to decouple.
    assign decouple[i] = (lane_st == DECOUPLED) | (decouple_req[i] & boundary);

    // Fires in the final DECOUPLED cycle, so the counter is fresh on re-couple.
    assign reload[i] = (lane_st == DECOUPLED) & ~decouple_req[i];

    assign decoupled[i] = (lane_st == DECOUPLED);  // Status seen outside the shell.

    always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
        lane_st <= ACTIVE;
        in_pkt  <= 1'b0;
      end else begin
        in_pkt <= in_pkt_nx;
        unique case (lane_st)
          ACTIVE: begin
            if (decouple_req[i]) begin
              // Cut at once between packets, otherwise let the packet finish.
              lane_st <= boundary ? DECOUPLED : DRAINING;
            end
          end
          DRAINING: begin
            if (!decouple_req[i]) begin
              lane_st <= ACTIVE;     // Request withdrawn, the region was never cut.
            end else if (boundary) begin
              lane_st <= DECOUPLED;  // Edge after the last beat of the packet.
            end
          end
          DECOUPLED: begin
            if (!decouple_req[i]) begin
              lane_st <= ACTIVE;  // Re-couple, reload happens on this edge.
            end
          end
          default: begin
            lane_st <= ACTIVE;
          end
        endcase
      end
    end
  end

endmodule

// ==== logic/pr_stream_shell.sv ====
/*
  Top level of the stream shell.
  Each lane has a receive buffer toward the static side and a decoupler
  toward its region. One controller sequences decoupling for all lanes.
  The sender starts with CREDITS credits per lane and must not send
  without one. Each region starts with RG_CREDITS credits.
*/
`timescale 1ns/1ps

module pr_stream_shell
  import pr_stream_pkg::*;
(
  input  logic                       aclk,
  input  logic                       arst_n,
  input  logic       [N_REGIONS-1:0] in_valid,
  input  axis_beat_t [N_REGIONS-1:0] in_beat,
  output logic       [N_REGIONS-1:0] in_credit,
  output logic       [N_REGIONS-1:0] out_valid,
  output axis_beat_t [N_REGIONS-1:0] out_beat,
  input  logic       [N_REGIONS-1:0] out_credit,
  input  logic       [N_REGIONS-1:0] decouple_req,
  output logic       [N_REGIONS-1:0] decoupled
);

  logic       [N_REGIONS-1:0] buf_valid;  // Buffer holds a beat.
  axis_beat_t [N_REGIONS-1:0] buf_beat;   // Head beat of each buffer.
  logic       [N_REGIONS-1:0] buf_pop;    // Decoupler takes the head beat.
  logic       [N_REGIONS-1:0] fire_last;  // Last beat of a packet went out.
  logic       [N_REGIONS-1:0] decouple;   // Gate each region off.
  logic       [N_REGIONS-1:0] reload;     // Restore region credits.

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_lane
    credit_fifo u_fifo (
      .aclk     (aclk),
      .arst_n   (arst_n),
      .wr_valid (in_valid[i]),
      .wr_beat  (in_beat[i]),
      .credit   (in_credit[i]),
      .rd_valid (buf_valid[i]),
      .rd_beat  (buf_beat[i]),
      .rd_pop   (buf_pop[i])
    );

    region_decoupler u_dcpl (
      .aclk       (aclk),
      .arst_n     (arst_n),
      .buf_valid  (buf_valid[i]),
      .buf_beat   (buf_beat[i]),
      .buf_pop    (buf_pop[i]),
      .out_valid  (out_valid[i]),
      .out_beat   (out_beat[i]),
      .out_credit (out_credit[i]),
      .decouple   (decouple[i]),
      .reload     (reload[i]),
      .fire_last  (fire_last[i])
    );
  end

  // out_valid doubles as the per-lane fire indication.
  reconfig_ctrl u_ctrl (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .decouple_req (decouple_req),
    .fire         (out_valid),
    .fire_last    (fire_last),
    .decouple     (decouple),
    .reload       (reload),
    .decoupled    (decoupled)
  );

endmodule

// ==== verif/pr_stream_props.sv ====
/*
  Protocol checks bound into pr_stream_shell.
  Buffer occupancy is rebuilt here from writes and pops, because the buffer
  itself never refuses a write. fail_cnt holds the number of failed checks
  over all lanes.
*/
`timescale 1ns/1ps

module pr_stream_props
  import pr_stream_pkg::*;
(
  input logic                 aclk,
  input logic                 arst_n,
  input logic [N_REGIONS-1:0] in_valid,
  input logic [N_REGIONS-1:0] in_credit,
  input logic [N_REGIONS-1:0] out_valid,
  input logic [N_REGIONS-1:0] buf_pop,
  input logic [N_REGIONS-1:0] reload,
  input logic [N_REGIONS-1:0] decouple_req,
  input logic [N_REGIONS-1:0] decoupled
);

  int fail_cnt = 0;  // Failed checks over all lanes.

  for (genvar i = 0; i < N_REGIONS; i++) begin : g_lane
    logic [CRED_BITS-1:0] occ;  // Beats held in this lane's buffer.

    always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
        occ <= '0;
      end else begin
        occ <= occ + CRED_BITS'(in_valid[i]) - CRED_BITS'(buf_pop[i]);  // Write in, pop out.
      end
    end

    // A write into a full buffer is only safe with a pop in the same cycle.
    a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n)
      in_valid[i] && occ == CRED_BITS'(CREDITS) |-> buf_pop[i])
      else begin
        fail_cnt++;
        $error("lane %0d wrote into a full receive buffer", i);
      end

    a_credit_per_pop: assert property (@(posedge aclk) disable iff (!arst_n)
      in_credit[i] == $past(buf_pop[i]))
      else begin
        fail_cnt++;
        $error("lane %0d upstream credit does not follow a pop", i);
      end

    a_out_per_pop: assert property (@(posedge aclk) disable iff (!arst_n)
      out_valid[i] == $past(buf_pop[i]))
      else begin
        fail_cnt++;
        $error("lane %0d out_valid does not follow a pop", i);
      end

    // A cut-off region sees nothing at all.
    a_quiet_decoupled: assert property (@(posedge aclk) disable iff (!arst_n)
      decoupled[i] |-> !out_valid[i] && !buf_pop[i])
      else begin
        fail_cnt++;
        $error("lane %0d moved a beat while decoupled", i);
      end

    // The region stays cut off for as long as the request is held.
    a_hold_decoupled: assert property (@(posedge aclk) disable iff (!arst_n)
      decoupled[i] && decouple_req[i] |=> decoupled[i])
      else begin
        fail_cnt++;
        $error("lane %0d re-coupled while the request was still held", i);
      end

    a_recouple: assert property (@(posedge aclk) disable iff (!arst_n)
      reload[i] |=> !decoupled[i] && !reload[i])
      else begin
        fail_cnt++;
        $error("lane %0d did not re-couple one cycle after reload", i);
      end
  end

endmodule

// ==== verif/pr_stream_tb.sv ====
/*
  Testbench for pr_stream_shell. Every lane sends random packets of 1 to 5
  beats and honors upstream credits. A region model returns credits after a
  random delay and toggles its credit line at random while decoupled.
  Each lane is decoupled once, mid-packet where possible, and released with
  region credits held back. Protocol rules live in the bound pr_stream_props.
*/
`timescale 1ns/1ps

module pr_stream_tb
  import pr_stream_pkg::*;
();

  logic                       aclk;
  logic                       arst_n;
  logic       [N_REGIONS-1:0] in_valid;
  axis_beat_t [N_REGIONS-1:0] in_beat;
  logic       [N_REGIONS-1:0] in_credit;
  logic       [N_REGIONS-1:0] out_valid;
  axis_beat_t [N_REGIONS-1:0] out_beat;
  logic       [N_REGIONS-1:0] out_credit;
  logic       [N_REGIONS-1:0] decouple_req;
  logic       [N_REGIONS-1:0] decoupled;

  axis_beat_t           exp_q [N_REGIONS][$];  // Sent beats not yet delivered.
  int                   snd_cred [N_REGIONS];  // Credits the sender holds.
  int                   pkt_left [N_REGIONS];  // Beats left in the open packet.
  int                   seq_no [N_REGIONS];    // Next sequence number per lane.
  int                   accepted [N_REGIONS];  // Beats handed to the shell.
  int                   credits_back [N_REGIONS];  // Upstream credits received.
  int                   delivered [N_REGIONS];  // Beats seen at the region.
  int                   in_flight [N_REGIONS];  // Beats the region has not credited.
  int                   ret_wait [N_REGIONS];   // Cycles until the next credit return.
  logic [N_REGIONS-1:0] send_en;      // Start new packets.
  logic [N_REGIONS-1:0] hold_credit;  // Region keeps its credits.
  logic [N_REGIONS-1:0] open_pkt;     // A packet is open on the region side.
  logic [N_REGIONS-1:0] decoupled_q;  // decoupled at the previous sample.
  int                   errors;

  always #50 aclk = ~aclk;  // 100 ns period.

  pr_stream_shell dut (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_beat      (in_beat),
    .in_credit    (in_credit),
    .out_valid    (out_valid),
    .out_beat     (out_beat),
    .out_credit   (out_credit),
    .decouple_req (decouple_req),
    .decoupled    (decoupled)
  );

  bind pr_stream_shell pr_stream_props u_props (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_credit    (in_credit),
    .out_valid    (out_valid),
    .buf_pop      (buf_pop),
    .reload       (reload),
    .decouple_req (decouple_req),
    .decoupled    (decoupled)
  );

  task automatic finish_run();
    int prop_fails;
    prop_fails = dut.u_props.fail_cnt;
    $display("Closing: %0d testbench errors, %0d assertion failures", errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout at %0t: %s", $time, what);
    finish_run();
  endtask

  task automatic check_idle_outputs(input string phase);
    assert (in_credit == '0 && out_valid == '0 && decoupled == '0) else begin
      errors++;
      $display("MISMATCH at %0t: outputs not idle %s, in_credit %b out_valid %b decoupled %b",
               $time, phase, in_credit, out_valid, decoupled);
    end
  endtask

  // Compares one region-side beat with the oldest beat sent on its lane.
  task automatic check_beat(input int lane, input axis_beat_t got);
    axis_beat_t exp;
    assert (exp_q[lane].size() > 0) else begin
      errors++;
      $display("Error at %0t: lane %0d delivered a beat that was never sent", $time, lane);
    end
    if (exp_q[lane].size() > 0) begin
      exp = exp_q[lane].pop_front();
      assert (got == exp) else begin
        errors++;
        $display("MISMATCH at %0t: lane %0d expected data %h keep %h id %0d last %b",
                 $time, lane, exp.data, exp.keep, exp.id, exp.last);
        $display("MISMATCH at %0t: lane %0d got data %h keep %h id %0d last %b",
                 $time, lane, got.data, got.keep, got.id, got.last);
      end
    end
    open_pkt[lane] = ~got.last;
    delivered[lane]++;
    in_flight[lane]++;
    assert (in_flight[lane] <= RG_CREDITS) else begin
      errors++;
      $display("Error at %0t: lane %0d has %0d beats in flight, more than the region granted",
               $time, lane, in_flight[lane]);
    end
  endtask

  // Region side credit return, glitchy while the region is cut off.
  task automatic model_region(input int lane);
    if (decoupled[lane]) begin
      in_flight[lane] = 0;  // The old region is gone with its pending credits.
      out_credit[lane] = ($urandom_range(0, 1) == 1);
    end else if (in_flight[lane] > 0 && !hold_credit[lane]) begin
      if (ret_wait[lane] == 0) begin
        out_credit[lane] = 1'b1;
        in_flight[lane]--;
        ret_wait[lane] = $urandom_range(0, 3);
      end else begin
        out_credit[lane] = 1'b0;
        ret_wait[lane]--;
      end
    end else begin
      out_credit[lane] = 1'b0;
    end
  endtask

  // Sends one beat when a credit is held; an open packet is always finished.
  task automatic send_next(input int lane);
    axis_beat_t beat;
    in_valid[lane] = 1'b0;
    if ((send_en[lane] || pkt_left[lane] != 0) && snd_cred[lane] > 0 &&
        $urandom_range(0, 3) != 0) begin
      if (pkt_left[lane] == 0) begin
        pkt_left[lane] = $urandom_range(1, 5);
      end
      beat.data = DATA_BITS'(seq_no[lane]);
      beat.keep = KEEP_BITS'($urandom);
      beat.id = PID_BITS'(lane);
      beat.last = (pkt_left[lane] == 1);
      in_beat[lane] = beat;
      in_valid[lane] = 1'b1;
      exp_q[lane].push_back(beat);
      snd_cred[lane]--;
      accepted[lane]++;
      seq_no[lane]++;
      pkt_left[lane]--;
    end
  endtask

  always @(negedge aclk) begin
    if (arst_n) begin
      for (int i = 0; i < N_REGIONS; i++) begin
        if (in_credit[i]) begin
          snd_cred[i]++;
          credits_back[i]++;
          assert (snd_cred[i] <= CREDITS) else begin
            errors++;
            $display("Error at %0t: lane %0d returned more credits than it has slots",
                     $time, i);
          end
        end
        if (out_valid[i]) begin
          check_beat(i, out_beat[i]);
        end
        if (decoupled[i] && !decoupled_q[i]) begin
          assert (!open_pkt[i]) else begin
            errors++;
            $display("Error at %0t: lane %0d was decoupled in the middle of a packet", $time, i);
          end
        end
        decoupled_q[i] = decoupled[i];
        model_region(i);
        send_next(i);
      end
    end
  end

  task automatic wait_decoupled(input int lane, input logic level, input int limit);
    int n;
    n = 0;
    while (decoupled[lane] !== level && n < limit) begin
      @(negedge aclk);
      n++;
    end
    if (decoupled[lane] !== level) begin
      report_timeout($sformatf("lane %0d decoupled never became %b", lane, level));
    end
  endtask

  task automatic wait_sender_blocked(input int lane, input int limit);
    int n;
    n = 0;
    while (snd_cred[lane] != 0 && n < limit) begin
      @(negedge aclk);
      n++;
    end
    if (snd_cred[lane] != 0) begin
      report_timeout($sformatf("lane %0d sender never ran out of credits", lane));
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    int left;
    n = 0;
    left = 1;
    while (left != 0 && n < limit) begin
      @(negedge aclk);
      n++;
      left = 0;
      for (int i = 0; i < N_REGIONS; i++) begin
        left += exp_q[i].size();
      end
    end
    if (left != 0) begin
      report_timeout($sformatf("%0d beats were never delivered", left));
    end
  endtask

  // Decouple, fill the buffer, then release with region credits held back.
  task automatic run_decouple(input int lane);
    int n;
    int base;
    n = 0;
    while (!open_pkt[lane] && n < 300) begin  // Prefer a request in mid-packet.
      @(negedge aclk);
      n++;
    end
    decouple_req[lane] = 1'b1;
    wait_decoupled(lane, 1'b1, 200);
    wait_sender_blocked(lane, 200);
    repeat (10) @(negedge aclk);  // Spurious credits hit the decoupled lane.
    base = delivered[lane];
    hold_credit[lane] = 1'b1;
    decouple_req[lane] = 1'b0;
    wait_decoupled(lane, 1'b0, 5);
    repeat (15) @(negedge aclk);
    assert (delivered[lane] - base == RG_CREDITS) else begin
      errors++;
      $display("MISMATCH at %0t: lane %0d sent %0d beats on a fresh grant, expected %0d",
               $time, lane, delivered[lane] - base, RG_CREDITS);
    end
    hold_credit[lane] = 1'b0;
  endtask

  initial begin
    void'($urandom(32'haa1b));
    aclk = 1'b0;
    arst_n = 1'b0;
    in_valid = '0;
    in_beat = '0;
    out_credit = '0;
    decouple_req = '0;
    send_en = '0;
    hold_credit = '0;
    open_pkt = '0;
    decoupled_q = '0;
    errors = 0;
    for (int i = 0; i < N_REGIONS; i++) begin
      snd_cred[i] = CREDITS;
      pkt_left[i] = 0;
      seq_no[i] = 0;
      accepted[i] = 0;
      credits_back[i] = 0;
      delivered[i] = 0;
      in_flight[i] = 0;
      ret_wait[i] = 0;
    end
    repeat (8) begin
      @(negedge aclk);
      check_idle_outputs("during reset");
    end
    arst_n = 1'b1;
    @(negedge aclk);
    check_idle_outputs("after reset");
    send_en = '1;  // All lanes run at once from here on.
    repeat (300) @(negedge aclk);
    for (int l = 0; l < N_REGIONS; l++) begin
      run_decouple(l);
    end
    repeat (100) @(negedge aclk);
    send_en = '0;
    wait_drained(500);
    repeat (4) @(negedge aclk);  // Last credits are still on their way.
    for (int l = 0; l < N_REGIONS; l++) begin
      assert (credits_back[l] == accepted[l]) else begin
        errors++;
        $display("MISMATCH at %0t: lane %0d returned %0d credits for %0d beats",
                 $time, l, credits_back[l], accepted[l]);
      end
    end
    finish_run();
  end

endmodule

// ==== all.f ====
logic/pr_stream_pkg.sv
logic/credit_fifo.sv
logic/region_decoupler.sv
logic/reconfig_ctrl.sv
logic/pr_stream_shell.sv
verif/pr_stream_props.sv
verif/pr_stream_tb.sv

// ==== Makefile ====
# Verilator build and run for the stream shell testbench.

SIM      ?= verilator
SIMFLAGS ?= --binary --assert --timing --timescale 1ns/1ps -j 0
TOP      ?= pr_stream_tb
FILELIST ?= all.f
OBJDIR   ?= obj_dir
RUNFLAGS ?= +verilator+error+limit+1000
PASS_MSG := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
